// File: compile.f
rtl/frontend_pkg.sv
rtl/fetch_if.sv
rtl/fetch_unit.sv
rtl/inst_buffer.sv
rtl/decode_unit.sv
rtl/frontend_top.sv
dv/frontend_assertions.sv
dv/frontend_tb.sv

// File: dv/frontend_assertions.sv
`timescale 1ns/1ns

module frontend_assertions (
    input logic                                                  clock,
    input logic                                                  reset,
    // buffer occupancy and this cycle's accept and dispatch counts
    input logic [$clog2(frontend_pkg::INST_BUFF_DEPTH+1)-1:0]    entry_count,
    input logic [$clog2(frontend_pkg::INST_BUFF_DEPTH+1)-1:0]    accept_n,
    input logic [$clog2(frontend_pkg::INST_BUFF_DEPTH+1)-1:0]    dispatch_n,
    // decode output register
    input logic                                                  redirect_valid,
    input logic [frontend_pkg::FETCH_WIDTH-1:0]                  dispatch_valid,
    input logic [frontend_pkg::FETCH_WIDTH*(2*frontend_pkg::XLEN
                 +3*frontend_pkg::REG_W)-1:0]                    dispatch_payload,
    input logic                                                  dispatch_ready
);
    import frontend_pkg::*;

    a_count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        int'(entry_count) <= INST_BUFF_DEPTH
    ) else $error("buffer entry count above depth");

    // accept must fit in the free space, dispatch included
    a_accept_fits: assert property (
        @(posedge clock) disable iff (reset)
        int'(accept_n) + int'(entry_count) <= INST_BUFF_DEPTH + int'(dispatch_n)
    ) else $error("fetch accepted more words than the buffer had room for");

    a_hold_when_stalled: assert property (
        @(posedge clock) disable iff (reset)
        (|dispatch_valid && !dispatch_ready && !redirect_valid)
            |=> ($stable(dispatch_valid) && $stable(dispatch_payload))
    ) else $error("dispatch outputs changed while stalled");

endmodule

bind inst_buffer frontend_assertions u_buffer_assertions (
    .clock            (clock),
    .reset            (reset),
    .entry_count      (entry_count),
    .accept_n         (accept_n),
    .dispatch_n       (dispatch_n),
    .redirect_valid   (1'b0),
    .dispatch_valid   ('0),
    .dispatch_payload ('0),
    .dispatch_ready   (1'b0)
);

bind decode_unit frontend_assertions u_decode_assertions (
    .clock            (clock),
    .reset            (reset),
    .entry_count      ('0),
    .accept_n         ('0),
    .dispatch_n       ('0),
    .redirect_valid   (redirect_valid),
    .dispatch_valid   (dispatch_valid),
    .dispatch_payload ({dispatch_pc, dispatch_rd, dispatch_rs1, dispatch_rs2, dispatch_imm}),
    .dispatch_ready   (dispatch_ready)
);

// File: dv/frontend_tb.sv
`timescale 1ns/1ns

module frontend_tb;
    import frontend_pkg::*;

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES = 4000;
    localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_CYCLES + 100) * PERIOD;
    localparam int OUT_W = FETCH_WIDTH * (1 + 2 * XLEN + 3 * REG_W);
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    logic                              clock;
    logic                              reset;
    logic [XLEN-1:0]                   fetch_addr;
    logic [FETCH_WIDTH-1:0][XLEN-1:0]  fetch_words;
    logic                              redirect_valid;
    logic [XLEN-1:0]                   redirect_pc;
    logic [FETCH_WIDTH-1:0]            dispatch_valid;
    logic [FETCH_WIDTH-1:0][XLEN-1:0]  dispatch_pc;
    logic [FETCH_WIDTH-1:0][REG_W-1:0] dispatch_rd;
    logic [FETCH_WIDTH-1:0][REG_W-1:0] dispatch_rs1;
    logic [FETCH_WIDTH-1:0][REG_W-1:0] dispatch_rs2;
    logic [FETCH_WIDTH-1:0][XLEN-1:0]  dispatch_imm;
    logic                              dispatch_ready;

    // instruction memory indexed by address bits 7 to 2
    logic [XLEN-1:0]  mem [0:63];
    logic [15:0]      lfsr_state;
    logic [XLEN-1:0]  exp_pc;
    int               mismatch_count;
    int               other_count;
    int               transfer_count;
    // outputs seen at the last falling edge
    logic             stalled;
    logic [OUT_W-1:0] held_state;
    logic [OUT_W-1:0] out_state;
    // redirect driven in the previous cycle
    logic             redirected;

    frontend_top dut (
        .clock          (clock),
        .reset          (reset),
        .fetch_addr     (fetch_addr),
        .fetch_words    (fetch_words),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dispatch_valid (dispatch_valid),
        .dispatch_pc    (dispatch_pc),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_ready (dispatch_ready)
    );

    initial clock = 1'b0;
    always #(PERIOD / 2) clock = ~clock;

    // same-cycle memory answer with lane i at fetch_addr + 4i
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            fetch_words[i] = mem[fetch_addr[7:2] + 6'(i)];
        end
    end

    assign out_state = {dispatch_valid, dispatch_pc, dispatch_rd,
                        dispatch_rs1, dispatch_rs2, dispatch_imm};

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s at %0t: expected %0h actual %0h",
                     name, $time, expected, actual);
            mismatch_count++;
        end
    endtask

    // model decode straight from the instruction bit layout
    task automatic check_lane(input int lane);
        logic [XLEN-1:0]  word;
        logic [XLEN-1:0]  exp_imm;
        logic [REG_W-1:0] exp_rs2;
        word = mem[exp_pc[7:2]];
        if (word[6:0] == OPCODE_OP) begin
            exp_rs2 = word[24:20];
            exp_imm = '0;
        end else begin
            exp_rs2 = '0;
            exp_imm = {{20{word[31]}}, word[31:20]};
        end
        check_value("pc", exp_pc, dispatch_pc[lane]);
        check_value("rd", word[11:7], dispatch_rd[lane]);
        check_value("rs1", word[19:15], dispatch_rs1[lane]);
        check_value("rs2", exp_rs2, dispatch_rs2[lane]);
        check_value("imm", exp_imm, dispatch_imm[lane]);
        exp_pc = exp_pc + 4;
        transfer_count++;
    endtask

    initial begin
        logic [3:0] ready_roll;
        lfsr_state = 16'd58;
        reset = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        dispatch_ready = 1'b0;
        mismatch_count = 0;
        other_count = 0;
        transfer_count = 0;
        exp_pc = '0;
        stalled = 1'b0;
        held_state = '0;
        redirected = 1'b0;
        for (int a = 0; a < 64; a++) begin
            mem[a] = random_bits(32);
            mem[a][6:0] = random_bits(1) ? OPCODE_OP : OPCODE_OP_IMM;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        dispatch_ready = 1'b1;
        check_value("fetch_addr_after_reset", '0, fetch_addr);
        // first group needs a fetch edge and a decode edge
        check_value("valid_after_reset", '0, dispatch_valid);
        @(negedge clock);
        check_value("valid_after_reset", '0, dispatch_valid);
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(negedge clock);
            if (stalled) begin
                check_value("hold_while_stalled", held_state, out_state);
            end
            if (redirected) begin
                check_value("fetch_addr_after_redirect", exp_pc, fetch_addr);
            end
            redirect_valid = (random_bits(6) == 0);
            redirect_pc = random_bits(10) << 2;
            ready_roll = random_bits(4);
            // backend does not accept in its redirect cycle
            dispatch_ready = !redirect_valid && (ready_roll < 11);
            if (dispatch_ready && |dispatch_valid) begin
                check_value("valid_order", '0, dispatch_valid & (dispatch_valid + 1'b1));
                for (int lane = 0; lane < FETCH_WIDTH; lane++) begin
                    if (dispatch_valid[lane]) begin
                        check_lane(lane);
                    end
                end
            end
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end
            redirected = redirect_valid;
            stalled = |dispatch_valid && !dispatch_ready && !redirect_valid;
            held_state = out_state;
        end
        if (transfer_count < NUM_CYCLES / 2) begin
            $display("error: only %0d instructions were dispatched", transfer_count);
            other_count++;
        end
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count + 1);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: rtl/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
    input  logic                                                          clock,
    input  logic                                                          reset,

    input  logic                                                          redirect_valid,

    input  frontend_pkg::rv_inst_u [frontend_pkg::FETCH_WIDTH-1:0]        head_insts,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  head_pcs,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0]                          head_valid,
    output logic [frontend_pkg::FETCH_CNT_W-1:0]                          num_dispatch,

    output logic [frontend_pkg::FETCH_WIDTH-1:0]                          dispatch_valid,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  dispatch_pc,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::REG_W-1:0] dispatch_rd,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::REG_W-1:0] dispatch_rs1,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::REG_W-1:0] dispatch_rs2,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  dispatch_imm,
    input  logic                                                          dispatch_ready
);
    import frontend_pkg::*;

    logic                                   can_load;
    logic [FETCH_WIDTH-1:0]                 lead_valid;
    logic [FETCH_CNT_W-1:0]                 lead_count;
    logic [FETCH_WIDTH-1:0][REG_W-1:0]      dec_rd;
    logic [FETCH_WIDTH-1:0][REG_W-1:0]      dec_rs1;
    logic [FETCH_WIDTH-1:0][REG_W-1:0]      dec_rs2;
    logic [FETCH_WIDTH-1:0][XLEN-1:0]       dec_imm;

    // register empty, or its group leaves at this edge
    assign can_load = !(|dispatch_valid) || dispatch_ready;

    // only the unbroken run of valid entries from the head
    always_comb begin
        lead_valid[0] = head_valid[0];
        for (int i = 1; i < FETCH_WIDTH; i++) begin
            lead_valid[i] = lead_valid[i-1] & head_valid[i];
        end
        lead_count = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lead_count = lead_count + FETCH_CNT_W'(lead_valid[i]);
        end
    end

    assign num_dispatch = (can_load && !redirect_valid) ? lead_count : '0;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            // rd and rs1 sit at the same bits in both formats
            dec_rd[i] = head_insts[i].r_view.rd;
            dec_rs1[i] = head_insts[i].r_view.rs1;
            if (head_insts[i].r_view.opcode == OPCODE_OP) begin
                // register-register op has no immediate
                dec_rs2[i] = head_insts[i].r_view.rs2;
                dec_imm[i] = '0;
            end else begin
                dec_rs2[i] = '0;
                dec_imm[i] = {{(XLEN-12){head_insts[i].i_view.imm12[11]}},
                              head_insts[i].i_view.imm12};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || redirect_valid) begin
            dispatch_valid <= '0;
        end else if (can_load) begin
            dispatch_valid <= lead_valid;
        end
    end

    // payload held while stalled
    always_ff @(posedge clock) begin
        if (can_load) begin
            dispatch_pc <= head_pcs;
            dispatch_rd <= dec_rd;
            dispatch_rs1 <= dec_rs1;
            dispatch_rs2 <= dec_rs2;
            dispatch_imm <= dec_imm;
        end
    end

endmodule

// File: rtl/fetch_if.sv
`timescale 1ns/1ns

interface fetch_if #(
    parameter int DEPTH = frontend_pkg::INST_BUFF_DEPTH
);
    import frontend_pkg::*;

    // fetch group, lane 0 is the oldest
    rv_inst_u [FETCH_WIDTH-1:0]            fill_insts;
    logic     [FETCH_WIDTH-1:0][XLEN-1:0]  fill_pcs;
    // words the buffer takes this cycle
    logic     [FETCH_CNT_W-1:0]            fill_count;
    // free entries, counting this cycle's dispatch
    logic     [$clog2(DEPTH+1)-1:0]        open_entries;
    logic                                  flush;

    modport fetch (
        output fill_insts,
        output fill_pcs,
        output fill_count,
        output flush,
        input  open_entries
    );

    modport buffer (
        input  fill_insts,
        input  fill_pcs,
        input  fill_count,
        input  flush,
        output open_entries
    );

endinterface

// File: rtl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                                                   clock,
    input  logic                                                   reset,

    input  logic                                                   redirect_valid,
    input  logic [frontend_pkg::XLEN-1:0]                          redirect_pc,

    // memory port, same-cycle answer
    output logic [frontend_pkg::XLEN-1:0]                          fetch_addr,
    input  frontend_pkg::rv_inst_u [frontend_pkg::FETCH_WIDTH-1:0] fetch_words,

    fetch_if.fetch                                                 fill
);
    import frontend_pkg::*;

    logic [XLEN-1:0] pc;

    assign fetch_addr = pc;

    // words and their pcs go to the buffer as one group
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            fill.fill_insts[i] = fetch_words[i];
            fill.fill_pcs[i] = pc + XLEN'(4 * i);
        end
    end

    // accept as many words as the buffer has room for
    always_comb begin
        if (redirect_valid) begin
            fill.fill_count = '0;
        end else if (fill.open_entries < FETCH_WIDTH) begin
            fill.fill_count = FETCH_CNT_W'(fill.open_entries);
        end else begin
            fill.fill_count = FETCH_CNT_W'(FETCH_WIDTH);
        end
    end

    // redirect wipes everything fetched so far
    assign fill.flush = redirect_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else begin
            // four bytes per accepted word, holds when the buffer is full
            pc <= pc + (XLEN'(fill.fill_count) << 2);
        end
    end

endmodule

// File: rtl/frontend_pkg.sv
package frontend_pkg;

    // instructions per fetch group and per dispatch group
    localparam int FETCH_WIDTH = 2;

    // instruction buffer entries, power of two
    localparam int INST_BUFF_DEPTH = 8;

    localparam int XLEN = 32;

    // architectural register index width
    localparam int REG_W = 5;

    // width of a per-group instruction count, 0 to FETCH_WIDTH
    localparam int FETCH_CNT_W = $clog2(FETCH_WIDTH + 1);

    // R-type integer register ops
    localparam logic [6:0] OPCODE_OP = 7'b0110011;

    // one instruction word, read as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0]       funct7;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [REG_W-1:0] rd;
            logic [6:0]       opcode;
        } r_view;
        struct packed {
            logic [11:0]      imm12;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [REG_W-1:0] rd;
            logic [6:0]       opcode;
        } i_view;
    } rv_inst_u;

endpackage

// File: rtl/frontend_top.sv
`timescale 1ns/1ns

module frontend_top (
    input  logic                                                          clock,
    input  logic                                                          reset,

    // instruction memory, lane i at fetch_addr + 4i
    output logic [frontend_pkg::XLEN-1:0]                                 fetch_addr,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  fetch_words,

    // backend redirect
    input  logic                                                          redirect_valid,
    input  logic [frontend_pkg::XLEN-1:0]                                 redirect_pc,

    // decoded group to the backend
    output logic [frontend_pkg::FETCH_WIDTH-1:0]                          dispatch_valid,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  dispatch_pc,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::REG_W-1:0] dispatch_rd,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::REG_W-1:0] dispatch_rs1,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::REG_W-1:0] dispatch_rs2,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  dispatch_imm,
    input  logic                                                          dispatch_ready
);
    import frontend_pkg::*;

    rv_inst_u [FETCH_WIDTH-1:0]           head_insts;
    logic     [FETCH_WIDTH-1:0][XLEN-1:0] head_pcs;
    logic     [FETCH_WIDTH-1:0]           head_valid;
    logic     [FETCH_CNT_W-1:0]           num_dispatch;

    fetch_if fill_bus ();

    fetch_unit u_fetch (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_addr     (fetch_addr),
        .fetch_words    (fetch_words),
        .fill           (fill_bus.fetch)
    );

    inst_buffer u_buffer (
        .clock        (clock),
        .reset        (reset),
        .fill         (fill_bus.buffer),
        .head_insts   (head_insts),
        .head_pcs     (head_pcs),
        .head_valid   (head_valid),
        .num_dispatch (num_dispatch)
    );

    decode_unit u_decode (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .head_insts     (head_insts),
        .head_pcs       (head_pcs),
        .head_valid     (head_valid),
        .num_dispatch   (num_dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_pc    (dispatch_pc),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_ready (dispatch_ready)
    );

endmodule

// File: rtl/inst_buffer.sv
`timescale 1ns/1ns

module inst_buffer #(
    parameter int DEPTH = frontend_pkg::INST_BUFF_DEPTH
) (
    input  logic                                                          clock,
    input  logic                                                          reset,

    fetch_if.buffer                                                       fill,

    // oldest entries, empty ones read as zero
    output frontend_pkg::rv_inst_u [frontend_pkg::FETCH_WIDTH-1:0]        head_insts,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  head_pcs,
    output logic [frontend_pkg::FETCH_WIDTH-1:0]                          head_valid,
    input  logic [frontend_pkg::FETCH_CNT_W-1:0]                          num_dispatch
);
    import frontend_pkg::*;

    logic [$clog2(DEPTH)-1:0]   head;
    logic [$clog2(DEPTH)-1:0]   tail;
    logic [$clog2(DEPTH+1)-1:0] entry_count;
    logic [$clog2(DEPTH+1)-1:0] dispatch_n;
    logic [$clog2(DEPTH+1)-1:0] accept_n;

    // entry storage, payload is only meaningful where valid is set
    rv_inst_u [DEPTH-1:0]           entry_inst;
    logic     [DEPTH-1:0][XLEN-1:0] entry_pc;
    logic     [DEPTH-1:0]           entry_valid;
    logic     [DEPTH-1:0]           next_valid;

    // wrapped slot index for each lane at head and at tail
    logic [FETCH_WIDTH-1:0][$clog2(DEPTH)-1:0] rd_ptr;
    logic [FETCH_WIDTH-1:0][$clog2(DEPTH)-1:0] wr_ptr;

    assign dispatch_n = ($clog2(DEPTH+1))'(num_dispatch);
    assign accept_n = ($clog2(DEPTH+1))'(fill.fill_count);

    // slots leaving this cycle count as free
    assign fill.open_entries = ($clog2(DEPTH+1))'(DEPTH) - entry_count + dispatch_n;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rd_ptr[i] = head + ($clog2(DEPTH))'(i);
            wr_ptr[i] = tail + ($clog2(DEPTH))'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            head_valid[i] = entry_valid[rd_ptr[i]];
            head_insts[i] = entry_valid[rd_ptr[i]] ? entry_inst[rd_ptr[i]] : '0;
            head_pcs[i] = entry_valid[rd_ptr[i]] ? entry_pc[rd_ptr[i]] : '0;
        end
    end

    // retire at head first, then fill at tail
    always_comb begin
        next_valid = entry_valid;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (i < num_dispatch) begin
                next_valid[rd_ptr[i]] = 1'b0;
            end
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (i < fill.fill_count) begin
                next_valid[wr_ptr[i]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || fill.flush) begin
            head <= '0;
            tail <= '0;
            entry_count <= '0;
            entry_valid <= '0;
        end else begin
            head <= head + ($clog2(DEPTH))'(num_dispatch);
            tail <= tail + ($clog2(DEPTH))'(fill.fill_count);
            entry_count <= entry_count - dispatch_n + accept_n;
            entry_valid <= next_valid;
        end
    end

    // fill_count is zero on flush, so no write slips through
    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (i < fill.fill_count) begin
                entry_inst[wr_ptr[i]] <= fill.fill_insts[i];
                entry_pc[wr_ptr[i]] <= fill.fill_pcs[i];
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
    -f compile.f -o frontend_sim \
    && ./obj_dir/frontend_sim > sim.log 2>&1 \
    && ! grep -q "Test failures found" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
